// ==== compile.f ====
logic/core_uarch_pkg.sv
logic/ldst_cmd_pkg.sv
logic/ldst_reg_pop.sv
logic/ldst_size_align.sv
logic/ldst_sequencer.sv
logic/ldst_unit.sv
testbench/ldst_checker.sv
testbench/ldst_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the load/store unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
	--top-module ldst_unit_tb --Mdir obj_dir -o ldst_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/ldst_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
	exit 0
fi
exit 1

// ==== testbench/ldst_unit_tb.sv ====
`default_nettype none

module ldst_unit_tb;

	typedef struct packed {
		logic load;
		logic multiple;
		logic pre;
		logic inc;
		logic wb;
		logic stall;
		logic [3:0] base_reg;
		logic [31:0] base;
		logic [31:0] offset;
		logic [15:0] operand;
	} entry_t;

	// worst case per command, sixteen registers with long stalls
	localparam int cycles_per_cmd = 200;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic cmd_valid = 1'b0;
	logic mem_ready = 1'b1;
	logic mem_rvalid = 1'b0;
	core_uarch_pkg::word mem_rdata = '0;
	logic cmd_ready, mem_valid, mem_write, wb_valid, fault;
	core_uarch_pkg::reg_num rd_num, wb_reg;
	core_uarch_pkg::ptr mem_addr;
	logic [3:0] mem_be;
	core_uarch_pkg::word mem_wdata, wb_value;

	entry_t tbl[$];
	entry_t cur = '0;
	logic [15:0][31:0] regs;
	core_uarch_pkg::word mem[core_uarch_pkg::ptr];
	logic [31:0] lfsr = 32'hf0ed_367f;
	logic stall_en = 1'b0;
	logic rd_req = 1'b0;
	core_uarch_pkg::ptr rd_addr = '0;
	int tests_done, tests_failed;

	always #4 clk = ~clk;

	// taps 32, 22, 2, 1
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// untouched memory reads back a value that mixes every address bit
	function automatic core_uarch_pkg::word fill(core_uarch_pkg::ptr p);
		return {p, 2'b00} * 32'h9e37_79b1 ^ 32'h8040_2010;
	endfunction

	function automatic core_uarch_pkg::word mem_read(core_uarch_pkg::ptr p);
		return mem.exists(p) ? mem[p] : fill(p);
	endfunction

	function automatic logic [15:0] single_op(logic [1:0] sz, logic sx, logic [3:0] rd);
		return {9'd0, sz, sx, rd};
	endfunction

	task automatic add(logic ld, logic mu, logic pre, logic inc, logic wb, logic st,
			logic [3:0] br, logic [31:0] base, logic [31:0] off, logic [15:0] op);
		tbl.push_back({ld, mu, pre, inc, wb, st, br, base, off, op});
	endtask

	task automatic fill_table();
		// single word loads, then sub-word loads at every legal offset
		add(1, 0, 1, 1, 1, 0, 4'd2, 32'h1000, 32'h8, single_op(2'd2, 0, 4'd1));
		add(1, 0, 0, 0, 1, 0, 4'd4, 32'h1040, 32'h10, single_op(2'd2, 0, 4'd3));
		for (int off = 0; off < 4; off++)
			for (int sx = 0; sx < 2; sx++) begin
				add(1, 0, 1, 1, 0, 0, 4'd6, 32'h1100, 32'(off + 4 * sx),
					single_op(2'd0, sx[0], 4'd7));
				if (off % 2 == 0)
					add(1, 0, 1, 1, 0, 0, 4'd6, 32'h1180, 32'(off + 4 * sx),
						single_op(2'd1, sx[0], 4'd8));
			end
		// stores
		add(0, 0, 1, 1, 0, 0, 4'd6, 32'h2000, 32'h1, single_op(2'd0, 0, 4'd5));
		add(0, 0, 1, 1, 0, 0, 4'd6, 32'h2000, 32'h3, single_op(2'd0, 0, 4'd9));
		add(0, 0, 0, 1, 1, 0, 4'd6, 32'h2002, 32'h6, single_op(2'd1, 0, 4'd10));
		add(0, 0, 1, 0, 0, 0, 4'd6, 32'h2010, 32'h4, single_op(2'd2, 0, 4'd11));
		// multiples on random lists
		add(1, 1, 1, 1, 1, 0, 4'd13, 32'h1200, 32'h0, 16'(rand_bits(16)));
		add(1, 1, 0, 1, 1, 0, 4'd13, 32'h1300, 32'h0, 16'(rand_bits(16)));
		add(0, 1, 1, 0, 1, 1, 4'd12, 32'h2100, 32'h0, 16'(rand_bits(16)));
		add(0, 1, 0, 0, 0, 1, 4'd12, 32'h2200, 32'h0, 16'(rand_bits(16)));
		add(0, 1, 0, 0, 1, 1, 4'd12, 32'h2300, 32'h0, 16'h0000);
		add(1, 1, 1, 1, 0, 1, 4'd12, 32'h2300, 32'h0, 16'h0000);
		// misaligned, writeback requested but must not happen
		add(1, 0, 1, 1, 1, 0, 4'd2, 32'h1000, 32'h1, single_op(2'd1, 0, 4'd1));
		add(0, 0, 0, 1, 1, 0, 4'd2, 32'h1002, 32'h4, single_op(2'd2, 0, 4'd1));
	endtask

	task automatic run_entry(entry_t e);
		logic taken;
		@(posedge clk);
		#1;
		cur = e;
		stall_en = e.stall;
		cmd_valid = 1'b1;
		do begin
			taken = cmd_ready;
			@(posedge clk);
			#1;
		end while (!taken);
		cmd_valid = 1'b0;
	endtask

	core_uarch_pkg::word rd_value_w;
	assign rd_value_w = regs[rd_num];

	ldst_unit ldst_unit_inst (
		.clk(clk), .rst_n(rst_n),
		.cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
		.cmd_load(cur.load), .cmd_multiple(cur.multiple), .cmd_pre(cur.pre),
		.cmd_increment(cur.inc), .cmd_writeback(cur.wb), .cmd_base_reg(cur.base_reg),
		.cmd_base(cur.base), .cmd_offset(cur.offset), .cmd_operand(cur.operand),
		.rd_num(rd_num), .rd_value(rd_value_w),
		.mem_valid(mem_valid), .mem_ready(mem_ready), .mem_addr(mem_addr),
		.mem_write(mem_write), .mem_be(mem_be), .mem_wdata(mem_wdata),
		.mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata),
		.wb_valid(wb_valid), .wb_reg(wb_reg), .wb_value(wb_value), .fault(fault)
	);

	ldst_checker checker_inst (
		.clk(clk), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
		.cmd_load(cur.load), .cmd_multiple(cur.multiple), .cmd_pre(cur.pre),
		.cmd_increment(cur.inc), .cmd_writeback(cur.wb), .cmd_base_reg(cur.base_reg),
		.cmd_base(cur.base), .cmd_offset(cur.offset), .cmd_operand(cur.operand),
		.regs(regs), .rd_num(rd_num),
		.mem_valid(mem_valid), .mem_ready(mem_ready), .mem_addr(mem_addr),
		.mem_write(mem_write), .mem_be(mem_be), .mem_wdata(mem_wdata),
		.mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata), .wb_valid(wb_valid),
		.wb_reg(wb_reg), .wb_value(wb_value), .fault(fault),
		.tests_done(tests_done), .tests_failed(tests_failed)
	);

	// memory and register models see settled handshakes at the falling edge
	always @(negedge clk) begin
		core_uarch_pkg::word w;
		rd_req = rst_n && mem_valid && mem_ready && !mem_write;
		rd_addr = mem_addr;
		if (rst_n && mem_valid && mem_ready && mem_write) begin
			w = mem_read(mem_addr);
			for (int b = 0; b < 4; b++)
				if (mem_be[b])
					w[8*b +: 8] = mem_wdata[8*b +: 8];
			mem[mem_addr] = w;
		end
		if (rst_n && wb_valid)
			regs[wb_reg] = wb_value;
	end

	always @(posedge clk) begin
		#1;
		mem_rvalid = rd_req;
		mem_rdata = rd_req ? mem_read(rd_addr) : '0;
		mem_ready = stall_en ? rand_bits(1) != 0 : 1'b1;
	end

	initial begin
		for (int i = 0; i < 16; i++)
			regs[i] = rand_bits(32);
		fill_table();
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		fork
			begin
				#(tbl.size() * cycles_per_cmd * 8);
				$display("watchdog expired before all commands completed");
				$display("SOME TESTS FAILED");
				$finish;
			end
		join_none
		foreach (tbl[i])
			run_entry(tbl[i]);
		wait (tests_done == tbl.size());
		$display("%0d tests run, %0d failed", tests_done, tests_failed);
		if (tests_failed == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/ldst_checker.sv ====
`default_nettype none

module ldst_checker (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    cmd_valid,
	input  logic                    cmd_ready,
	input  logic                    cmd_load,
	input  logic                    cmd_multiple,
	input  logic                    cmd_pre,
	input  logic                    cmd_increment,
	input  logic                    cmd_writeback,
	input  core_uarch_pkg::reg_num  cmd_base_reg,
	input  core_uarch_pkg::word     cmd_base,
	input  core_uarch_pkg::word     cmd_offset,
	input  logic [15:0]             cmd_operand,
	input  logic [15:0][31:0]       regs,
	input  core_uarch_pkg::reg_num  rd_num,
	input  logic                    mem_valid,
	input  logic                    mem_ready,
	input  core_uarch_pkg::ptr      mem_addr,
	input  logic                    mem_write,
	input  logic [3:0]              mem_be,
	input  core_uarch_pkg::word     mem_wdata,
	input  logic                    mem_rvalid,
	input  core_uarch_pkg::word     mem_rdata,
	input  logic                    wb_valid,
	input  core_uarch_pkg::reg_num  wb_reg,
	input  core_uarch_pkg::word     wb_value,
	input  logic                    fault,
	output int                      tests_done,
	output int                      tests_failed
);

	core_uarch_pkg::ptr q_addr[$];
	logic q_write[$];
	logic [3:0] q_be[$];
	core_uarch_pkg::reg_num q_rd[$];
	core_uarch_pkg::word q_data[$];
	core_uarch_pkg::reg_num q_lreg[$];
	logic [1:0] q_lsize[$];
	logic q_lsign[$];
	logic [1:0] q_loff[$];
	core_uarch_pkg::reg_num q_wreg[$];
	core_uarch_pkg::word q_wval[$];
	logic busy, base_due, fault_due;
	core_uarch_pkg::reg_num base_reg;
	core_uarch_pkg::word base_val;
	int errs;

	// load result as the architecture defines it
	function automatic core_uarch_pkg::word extend(core_uarch_pkg::word d, logic [1:0] off,
			logic [1:0] sz, logic sx);
		logic [7:0] b;
		logic [15:0] h;
		b = d[8*off +: 8];
		h = off[1] ? d[31:16] : d[15:0];
		if (sz == 2'd0)
			return sx ? {{24{b[7]}}, b} : {24'd0, b};
		if (sz == 2'd1)
			return sx ? {{16{h[15]}}, h} : {16'd0, h};
		return d;
	endfunction

	// one enable for each byte that the access covers
	function automatic logic [3:0] lanes(logic [1:0] off, logic [1:0] sz);
		logic [3:0] be;
		be = '0;
		for (int b = 0; b < 4; b++)
			be[b] = b >= off && b < off + (1 << sz);
		return be;
	endfunction

	task automatic push_req(core_uarch_pkg::word a, logic w, logic [3:0] be,
			core_uarch_pkg::reg_num r, core_uarch_pkg::word d);
		q_addr.push_back(a[31:2]);
		q_write.push_back(w);
		q_be.push_back(be);
		q_rd.push_back(r);
		q_data.push_back(d);
	endtask

	task automatic push_load(core_uarch_pkg::reg_num r, logic [1:0] sz, logic sx,
			logic [1:0] off);
		q_lreg.push_back(r);
		q_lsize.push_back(sz);
		q_lsign.push_back(sx);
		q_loff.push_back(off);
	endtask

	task automatic mismatch(string sig, core_uarch_pkg::word exp, core_uarch_pkg::word act);
		$display("FAIL at %0t: %s expected %h, got %h", $time, sig, exp, act);
		errs++;
	endtask

	task automatic problem(string what);
		$display("at %0t: %s", $time, what);
		errs++;
	endtask

	task automatic predict();
		core_uarch_pkg::word a;
		logic [1:0] sz;
		core_uarch_pkg::reg_num rd;
		int n;
		int i;
		base_due = cmd_writeback;
		fault_due = 1'b0;
		base_reg = cmd_base_reg;
		a = cmd_base;
		if (cmd_multiple) begin
			n = $countones(cmd_operand);
			for (int k = 0; k < 16; k++) begin
				i = cmd_increment ? k : 15 - k;
				if (cmd_operand[i]) begin
					if (cmd_pre)
						a = cmd_increment ? a + 32'd4 : a - 32'd4;
					push_req(a, !cmd_load, 4'hf, core_uarch_pkg::reg_num'(i), regs[i]);
					if (cmd_load)
						push_load(core_uarch_pkg::reg_num'(i), 2'd2, 1'b0, 2'd0);
					if (!cmd_pre)
						a = cmd_increment ? a + 32'd4 : a - 32'd4;
				end
			end
			base_val = cmd_increment ? cmd_base + 32'(4 * n) : cmd_base - 32'(4 * n);
		end else begin
			sz = cmd_operand[6:5];
			rd = cmd_operand[3:0];
			base_val = cmd_increment ? cmd_base + cmd_offset : cmd_base - cmd_offset;
			if (cmd_pre)
				a = base_val;
			if ((sz == 2'd1 && a[0]) || (sz >= 2'd2 && a[1:0] != 2'd0)) begin
				fault_due = 1'b1;
				base_due = 1'b0;
			end else if (cmd_load) begin
				push_req(a, 1'b0, 4'hf, rd, '0);
				push_load(rd, sz, cmd_operand[4], a[1:0]);
			end else begin
				push_req(a, 1'b1, lanes(a[1:0], sz), rd, regs[rd] << (8 * a[1:0]));
			end
		end
		busy = 1'b1;
	endtask

	task automatic end_test();
		if (q_addr.size() != 0)
			problem("a memory request never appeared");
		if (q_lreg.size() != 0 || q_wreg.size() != 0)
			problem("a load writeback never appeared");
		if (base_due)
			problem("the base writeback never appeared");
		if (fault_due)
			problem("no fault strobe for a misaligned transfer");
		$display("test %0d %s", tests_done, errs == 0 ? "ok" : "failed");
		if (errs != 0)
			tests_failed++;
		tests_done++;
		busy = 1'b0;
		errs = 0;
	endtask

	// sampled half a cycle after the edge, when the DUT outputs have settled
	always @(negedge clk) begin
		core_uarch_pkg::word mask;
		if (!rst_n) begin
			busy = 1'b0;
			errs = 0;
			tests_done = 0;
			tests_failed = 0;
		end else begin
			if (mem_valid && mem_ready) begin
				if (q_addr.size() == 0) begin
					problem("memory request that was not expected");
				end else begin
					for (int b = 0; b < 4; b++)
						mask[8*b +: 8] = {8{q_be[0][b]}};
					if (mem_addr != q_addr[0])
						mismatch("mem_addr", 32'(q_addr[0]), 32'(mem_addr));
					if (mem_write != q_write[0])
						mismatch("mem_write", 32'(q_write[0]), 32'(mem_write));
					if (q_write[0] && rd_num != q_rd[0])
						mismatch("rd_num", 32'(q_rd[0]), 32'(rd_num));
					if (q_write[0] && mem_be != q_be[0])
						mismatch("mem_be", 32'(q_be[0]), 32'(mem_be));
					if (q_write[0] && (mem_wdata & mask) != (q_data[0] & mask))
						mismatch("mem_wdata", q_data[0] & mask, mem_wdata & mask);
					void'(q_addr.pop_front());
					void'(q_write.pop_front());
					void'(q_be.pop_front());
					void'(q_rd.pop_front());
					void'(q_data.pop_front());
				end
			end
			if (busy && mem_rvalid && q_lreg.size() != 0) begin
				q_wreg.push_back(q_lreg.pop_front());
				q_wval.push_back(extend(mem_rdata, q_loff.pop_front(),
					q_lsize.pop_front(), q_lsign.pop_front()));
			end
			if (wb_valid) begin
				if (q_wreg.size() != 0) begin
					if (wb_reg != q_wreg[0])
						mismatch("wb_reg", 32'(q_wreg[0]), 32'(wb_reg));
					if (wb_value != q_wval[0])
						mismatch("wb_value", q_wval[0], wb_value);
					void'(q_wreg.pop_front());
					void'(q_wval.pop_front());
				end else if (busy && base_due) begin
					if (wb_reg != base_reg)
						mismatch("wb_reg", 32'(base_reg), 32'(wb_reg));
					if (wb_value != base_val)
						mismatch("wb_value", base_val, wb_value);
					base_due = 1'b0;
				end else begin
					problem("writeback that was not expected");
				end
			end
			if (fault) begin
				if (busy && fault_due)
					fault_due = 1'b0;
				else
					problem("fault strobe that was not expected");
			end
			if (busy && cmd_ready)
				end_test();
			if (!busy && cmd_valid && cmd_ready)
				predict();
		end
	end

endmodule

`default_nettype wire

// ==== logic/ldst_unit.sv ====
`default_nettype none

module ldst_unit (
	input  logic                                  clk,
	input  logic                                  rst_n,

	input  logic                                  cmd_valid,
	output logic                                  cmd_ready,
	input  logic                                  cmd_load,
	input  logic                                  cmd_multiple,
	input  logic                                  cmd_pre,
	input  logic                                  cmd_increment,
	input  logic                                  cmd_writeback,
	input  core_uarch_pkg::reg_num                cmd_base_reg,
	input  core_uarch_pkg::word                   cmd_base,
	input  core_uarch_pkg::word                   cmd_offset,
	input  ldst_cmd_pkg::ldst_operand             cmd_operand,

	output core_uarch_pkg::reg_num                rd_num,
	input  core_uarch_pkg::word                   rd_value,

	output logic                                  mem_valid,
	input  logic                                  mem_ready,
	output core_uarch_pkg::ptr                    mem_addr,
	output logic                                  mem_write,
	output logic [core_uarch_pkg::word_bytes-1:0] mem_be,
	output core_uarch_pkg::word                   mem_wdata,
	input  logic                                  mem_rvalid,
	input  core_uarch_pkg::word                   mem_rdata,

	output logic                                  wb_valid,
	output core_uarch_pkg::reg_num                wb_reg,
	output core_uarch_pkg::word                   wb_value,
	output logic                                  fault
);

	logic pop_valid, sign_extend, fault_raw;
	logic [1:0] addr_low;
	logic [core_uarch_pkg::word_bytes-1:0] byteenable;
	core_uarch_pkg::reg_num pop_lower, pop_upper;
	core_uarch_pkg::reg_list cur_regs, next_lower, next_upper;
	core_uarch_pkg::ldst_size size;
	core_uarch_pkg::word read;

	ldst_sequencer sequencer_inst (
		.clk(clk),
		.rst_n(rst_n),
		.cmd_valid(cmd_valid),
		.cmd_load(cmd_load),
		.cmd_multiple(cmd_multiple),
		.cmd_pre(cmd_pre),
		.cmd_increment(cmd_increment),
		.cmd_writeback(cmd_writeback),
		.cmd_base_reg(cmd_base_reg),
		.cmd_base(cmd_base),
		.cmd_offset(cmd_offset),
		.cmd_operand(cmd_operand),
		.cmd_ready(cmd_ready),
		.rd_num(rd_num),
		.rd_value(rd_value),
		.mem_valid(mem_valid),
		.mem_ready(mem_ready),
		.mem_addr(mem_addr),
		.mem_write(mem_write),
		.mem_be_sel(mem_be),
		.mem_rvalid(mem_rvalid),
		.pop_valid(pop_valid),
		.pop_lower(pop_lower),
		.pop_upper(pop_upper),
		.next_lower(next_lower),
		.next_upper(next_upper),
		.cur_regs(cur_regs),
		.size(size),
		.sign_extend(sign_extend),
		.addr_low(addr_low),
		.byteenable(byteenable),
		.read(read),
		.fault_raw(fault_raw),
		.wb_valid(wb_valid),
		.wb_reg(wb_reg),
		.wb_value(wb_value),
		.fault(fault)
	);

	ldst_reg_pop pop_inst (
		.regs(cur_regs),
		.valid(pop_valid),
		.pop_lower(pop_lower),
		.pop_upper(pop_upper),
		.next_lower(next_lower),
		.next_upper(next_upper)
	);

	ldst_size_align size_inst (
		.addr_low(addr_low),
		.size(size),
		.sign_extend(sign_extend),
		.store_value(rd_value),
		.load_data(mem_rdata),
		.byteenable(byteenable),
		.store_lanes(mem_wdata),
		.read(read),
		.fault(fault_raw)
	);

endmodule

`default_nettype wire

// ==== logic/ldst_sequencer.sv ====
`default_nettype none

module ldst_sequencer (
	input  logic                                  clk,
	input  logic                                  rst_n,

	input  logic                                  cmd_valid,
	input  logic                                  cmd_load,
	input  logic                                  cmd_multiple,
	input  logic                                  cmd_pre,
	input  logic                                  cmd_increment,
	input  logic                                  cmd_writeback,
	input  core_uarch_pkg::reg_num                cmd_base_reg,
	input  core_uarch_pkg::word                   cmd_base,
	input  core_uarch_pkg::word                   cmd_offset,
	input  ldst_cmd_pkg::ldst_operand             cmd_operand,
	output logic                                  cmd_ready,

	output core_uarch_pkg::reg_num                rd_num,
	input  core_uarch_pkg::word                   rd_value,

	output logic                                  mem_valid,
	input  logic                                  mem_ready,
	output core_uarch_pkg::ptr                    mem_addr,
	output logic                                  mem_write,
	output logic [core_uarch_pkg::word_bytes-1:0] mem_be_sel,
	input  logic                                  mem_rvalid,

	input  logic                                  pop_valid,
	input  core_uarch_pkg::reg_num                pop_lower,
	input  core_uarch_pkg::reg_num                pop_upper,
	input  core_uarch_pkg::reg_list               next_lower,
	input  core_uarch_pkg::reg_list               next_upper,
	output core_uarch_pkg::reg_list               cur_regs,

	output core_uarch_pkg::ldst_size              size,
	output logic                                  sign_extend,
	output logic [1:0]                            addr_low,
	input  logic [core_uarch_pkg::word_bytes-1:0] byteenable,
	input  core_uarch_pkg::word                   read,
	input  logic                                  fault_raw,

	output logic                                  wb_valid,
	output core_uarch_pkg::reg_num                wb_reg,
	output core_uarch_pkg::word                   wb_value,
	output logic                                  fault
);

	typedef enum logic [2:0] {
		st_idle,
		st_request,
		st_wait_read,
		st_load_writeback,
		st_base_writeback
	} state_t;

	state_t state;

	logic load, multiple, increment, writeback;
	logic accept, xfer_done, last, load_wb;
	core_uarch_pkg::reg_num base_reg, single_rd, load_reg;
	core_uarch_pkg::word addr, new_base, load_value, cmd_step, cmd_span;
	core_uarch_pkg::reg_list next_regs;

	function automatic core_uarch_pkg::word step_addr(core_uarch_pkg::word a,
			core_uarch_pkg::word b, logic up);
		return up ? a + b : a - b;
	endfunction

	assign cmd_ready = state == st_idle;
	assign accept = cmd_valid && cmd_ready;

	// singles step by the offset, multiples by one word per register
	assign cmd_step = cmd_multiple ?
		core_uarch_pkg::word'(core_uarch_pkg::word_bytes) : cmd_offset;
	assign cmd_span = cmd_multiple ?
		core_uarch_pkg::word'($countones(cmd_operand.regs)) *
		core_uarch_pkg::word'(core_uarch_pkg::word_bytes) : cmd_offset;

	assign rd_num = multiple ? (increment ? pop_lower : pop_upper) : single_rd;
	assign next_regs = increment ? next_lower : next_upper;
	assign last = !multiple || next_regs == '0;

	assign mem_valid = state == st_request && (multiple ? pop_valid : !fault_raw);
	assign fault = state == st_request && !multiple && fault_raw;
	assign mem_addr = addr[31:2];
	assign addr_low = addr[1:0];
	assign mem_write = !load;
	// reads fetch the whole word, the lane is picked on the way back
	assign mem_be_sel = load ? '1 : byteenable;

	assign xfer_done = (state == st_request && mem_valid && mem_ready && !load) ||
		(state == st_wait_read && mem_rvalid);

	// load and base writebacks never fall in the same cycle
	assign wb_valid = load_wb || state == st_base_writeback;
	assign wb_reg = load_wb ? load_reg : base_reg;
	assign wb_value = load_wb ? load_value : new_base;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			load_wb <= 1'b0;
		end else begin
			load_wb <= state == st_wait_read && mem_rvalid;

			case (state)
				st_idle:
					if (accept) begin
						if (cmd_multiple && cmd_operand.regs == '0)
							state <= cmd_writeback ? st_base_writeback : st_idle;
						else
							state <= st_request;
					end

				st_request:
					if (fault)
						state <= st_idle;
					else if (mem_valid && mem_ready) begin
						if (load)
							state <= st_wait_read;
						else if (last)
							state <= writeback ? st_base_writeback : st_idle;
					end

				st_wait_read:
					if (mem_rvalid)
						state <= last ? st_load_writeback : st_request;

				st_load_writeback:
					state <= writeback ? st_base_writeback : st_idle;

				default:
					state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			load <= cmd_load;
			multiple <= cmd_multiple;
			increment <= cmd_increment;
			writeback <= cmd_writeback;
			base_reg <= cmd_base_reg;
			addr <= cmd_pre ? step_addr(cmd_base, cmd_step, cmd_increment) : cmd_base;
			new_base <= step_addr(cmd_base, cmd_span, cmd_increment);

			if (cmd_multiple) begin
				cur_regs <= cmd_operand.regs;
				size <= core_uarch_pkg::size_word;
				sign_extend <= 1'b0;
				single_rd <= '0;
			end else begin
				cur_regs <= '0;
				size <= cmd_operand.single.size;
				sign_extend <= cmd_operand.single.sign_extend;
				single_rd <= cmd_operand.single.rd;
			end
		end else if (xfer_done) begin
			addr <= step_addr(addr, core_uarch_pkg::word'(core_uarch_pkg::word_bytes),
				increment);
			cur_regs <= next_regs;
		end

		// rd_num still names the register of the load in flight
		if (state == st_wait_read && mem_rvalid) begin
			load_reg <= rd_num;
			load_value <= read;
		end
	end

	mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
		mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_write));

	wb_fault_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(wb_valid && fault));

endmodule

`default_nettype wire

// ==== logic/ldst_size_align.sv ====
`default_nettype none

module ldst_size_align (
	input  logic [1:0]                             addr_low,
	input  core_uarch_pkg::ldst_size               size,
	input  logic                                   sign_extend,
	input  core_uarch_pkg::word                    store_value,
	input  core_uarch_pkg::word                    load_data,

	output logic [core_uarch_pkg::word_bytes-1:0]  byteenable,
	output core_uarch_pkg::word                    store_lanes,
	output core_uarch_pkg::word                    read,
	output logic                                   fault
);

	core_uarch_pkg::word shifted;

	// store side, data copied into every lane so the enables pick the right one
	always_comb begin
		case (size)
			core_uarch_pkg::size_byte: begin
				byteenable = 4'b0001 << addr_low;
				store_lanes = {4{store_value[7:0]}};
			end

			core_uarch_pkg::size_half: begin
				byteenable = addr_low[1] ? 4'b1100 : 4'b0011;
				store_lanes = {2{store_value[15:0]}};
			end

			default: begin
				byteenable = 4'b1111;
				store_lanes = store_value;
			end
		endcase
	end

	// load side
	assign shifted = load_data >> {addr_low, 3'b000};

	always_comb begin
		case (size)
			core_uarch_pkg::size_byte:
				read = {{24{sign_extend & shifted[7]}}, shifted[7:0]};

			core_uarch_pkg::size_half:
				read = {{16{sign_extend & shifted[15]}}, shifted[15:0]};

			default:
				read = load_data;
		endcase
	end

	// halfwords need an even offset, words a zero one
	always_comb begin
		case (size)
			core_uarch_pkg::size_byte:
				fault = 1'b0;

			core_uarch_pkg::size_half:
				fault = addr_low[0];

			default:
				fault = addr_low != 2'b00;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/ldst_reg_pop.sv ====
`default_nettype none

module ldst_reg_pop (
	input  core_uarch_pkg::reg_list regs,

	output logic                    valid,
	output core_uarch_pkg::reg_num  pop_lower,
	output core_uarch_pkg::reg_num  pop_upper,
	output core_uarch_pkg::reg_list next_lower,
	output core_uarch_pkg::reg_list next_upper
);

	always_comb begin
		valid = regs != '0;
		pop_lower = '0;
		pop_upper = '0;

		// scanning downwards leaves the lowest set bit in pop_lower
		for (int i = $bits(regs) - 1; i >= 0; i--) begin
			if (regs[i])
				pop_lower = core_uarch_pkg::reg_num'(i);
		end

		for (int i = 0; i < $bits(regs); i++) begin
			if (regs[i])
				pop_upper = core_uarch_pkg::reg_num'(i);
		end

		// both encoders look at the same list
		if (valid)
			assert (pop_lower <= pop_upper);
	end

	assign next_lower = regs & ~(core_uarch_pkg::reg_list'(1) << pop_lower);
	assign next_upper = regs & ~(core_uarch_pkg::reg_list'(1) << pop_upper);

endmodule

`default_nettype wire

// ==== logic/ldst_cmd_pkg.sv ====
`default_nettype none

package ldst_cmd_pkg;

	localparam int operand_bits = 16;

	// bits taken by the single transfer fields, the rest is padding
	localparam int single_used_bits = 7;
	localparam int single_pad_bits = operand_bits - single_used_bits;

	// operand as seen by a single transfer
	typedef struct packed {
		logic [single_pad_bits-1:0] pad;
		core_uarch_pkg::ldst_size   size;
		logic                       sign_extend;
		core_uarch_pkg::reg_num     rd;
	} ldst_single;

	// cmd_multiple picks which view is meaningful
	typedef union packed {
		core_uarch_pkg::reg_list regs;
		ldst_single              single;
	} ldst_operand;

endpackage

`default_nettype wire

// ==== logic/core_uarch_pkg.sv ====
`default_nettype none

package core_uarch_pkg;

	// one machine word
	typedef logic [31:0] word;

	// word address, the byte address without its two low bits
	typedef logic [29:0] ptr;

	typedef logic [3:0] reg_num;

	// one bit per architectural register, r0 in bit 0
	typedef logic [15:0] reg_list;

	typedef enum logic [1:0] {
		size_byte = 2'b00,
		size_half = 2'b01,
		size_word = 2'b10
	} ldst_size;

	localparam int word_bytes = 4;

endpackage

`default_nettype wire
